/* hdl/pp_cfg_pkg.sv */
`default_nettype none

package pp_cfg_pkg;

    // ============================================================
    // sizes
    // ============================================================
    // output channels handled per group
    localparam int TOUT         = 4;
    localparam int W_SIZE       = 8;
    localparam int W_CHN        = 6;

    localparam int PSUM_DW      = 32;
    localparam int OUT_DW       = 8;

    // bias and scale buffers, one word per output channel
    localparam int AFFINE_DW    = 32;
    localparam int AFFINE_AW    = 9;
    localparam int AFFINE_DEPTH = 512;

    // one psum entry per column
    localparam int PSUM_AW      = 8;
    localparam int PSUM_DEPTH   = 256;

    localparam int OFM_AW       = 20;

    // ============================================================
    // scalar types
    // ============================================================
    typedef logic        [W_SIZE-1:0]    size_t;
    typedef logic        [W_CHN-1:0]     chn_t;
    typedef logic signed [PSUM_DW-1:0]   psum_t;
    typedef logic        [3:0]           shift_t;
    typedef logic        [AFFINE_AW-1:0] affine_addr_t;
    typedef logic        [OFM_AW-1:0]    ofm_addr_t;

endpackage

`default_nettype wire

/* hdl/pp_data_pkg.sv */
`default_nettype none

package pp_data_pkg;

    // one partial sum per output lane
    typedef pp_cfg_pkg::psum_t [pp_cfg_pkg::TOUT-1:0] psum_vec_t;

    // beat from the PE array
    typedef struct packed {
        logic               vld;
        logic               first;
        logic               last;
        pp_cfg_pkg::size_t  row;
        pp_cfg_pkg::size_t  col;
        pp_cfg_pkg::chn_t   grp;
        psum_vec_t          data;
    } pe_beat_t;

    // packed output pixels, lane 0 in the low byte
    typedef struct packed {
        logic [pp_cfg_pkg::TOUT-1:0][pp_cfg_pkg::OUT_DW-1:0] lane;
    } ofm_word_t;

    // scale word, only the low byte carries the one-hot value
    typedef struct packed {
        logic [pp_cfg_pkg::AFFINE_DW-9:0] rsvd;
        logic [7:0]                       onehot;
    } scale_view_t;

    // same stream word seen as bias or as scale
    typedef union packed {
        logic signed [pp_cfg_pkg::AFFINE_DW-1:0] bias;
        scale_view_t                             scale;
    } affine_word_u;

endpackage

`default_nettype wire

/* hdl/dpram.sv */
`default_nettype none

module dpram #(
    parameter int DEPTH = 256,
    parameter int AW    = 8,
    parameter int DW    = 32
) (
    input  wire logic          clk,
    // write side
    input  wire logic          i_we,
    input  wire logic [AW-1:0] i_waddr,
    input  wire logic [DW-1:0] i_wdata,
    // read side
    input  wire logic          i_re,
    input  wire logic [AW-1:0] i_raddr,
    output      logic [DW-1:0] o_rdata
);

    logic [DW-1:0] mem [DEPTH];

    always_ff @(posedge clk) begin
        if (i_we) begin
            mem[i_waddr] <= i_wdata;
        end
        // read returns the old word on a same-address write
        if (i_re) begin
            o_rdata <= mem[i_raddr];
        end
    end

endmodule

`default_nettype wire

/* hdl/affine_loader.sv */
`default_nettype none

module affine_loader (
    input  wire logic                      clk,
    input  wire logic                      rstn,
    input  wire logic                      i_load_bias,
    input  wire logic                      i_load_scale,
    input  wire pp_cfg_pkg::chn_t          i_chn_groups,
    input  wire pp_data_pkg::affine_word_u i_rd_data,
    input  wire logic                      i_rd_vld,
    output      logic                      o_bias_we,
    output      logic                      o_scale_we,
    output      pp_cfg_pkg::affine_addr_t  o_waddr,
    output      pp_data_pkg::affine_word_u o_wdata,
    output      logic                      o_load_done
);

    import pp_cfg_pkg::*;
    import pp_data_pkg::*;

    logic         load_bias_d;
    logic         load_scale_d;
    logic         busy;
    logic         to_scale;
    affine_addr_t waddr;
    affine_word_u wdata_q;
    logic         wvld_q;
    affine_addr_t load_words;
    logic         last_wr;

    wire bias_start  = i_load_bias & ~load_bias_d;
    wire scale_start = i_load_scale & ~load_scale_d;

    // TOUT words per channel group
    assign load_words = affine_addr_t'(i_chn_groups) * affine_addr_t'(TOUT);
    assign last_wr    = busy & wvld_q & (waddr == load_words - 1'b1);

    // stream word held one cycle before the write
    always_ff @(posedge clk) begin
        wdata_q <= i_rd_data;
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            load_bias_d  <= 1'b0;
            load_scale_d <= 1'b0;
            wvld_q       <= 1'b0;
            busy         <= 1'b0;
            to_scale     <= 1'b0;
            waddr        <= '0;
            o_load_done  <= 1'b0;
        end else begin
            load_bias_d  <= i_load_bias;
            load_scale_d <= i_load_scale;
            wvld_q       <= i_rd_vld;
            o_load_done  <= last_wr & to_scale;
            if (!busy && (bias_start || scale_start)) begin
                busy     <= 1'b1;
                // bias wins when both rise together
                to_scale <= ~bias_start;
                waddr    <= '0;
            end else if (busy && wvld_q) begin
                waddr <= waddr + 1'b1;
                if (last_wr) begin
                    busy <= 1'b0;
                end
            end
        end
    end

    assign o_bias_we  = busy & wvld_q & ~to_scale;
    assign o_scale_we = busy & wvld_q & to_scale;
    assign o_waddr    = waddr;
    assign o_wdata    = wdata_q;

endmodule

`default_nettype wire

/* hdl/affine_fetch.sv */
`default_nettype none

module affine_fetch (
    input  wire logic                      clk,
    input  wire logic                      rstn,
    input  wire logic                      i_csync_run,
    input  wire pp_cfg_pkg::chn_t          i_chn_out,
    input  wire logic                      i_bias_we,
    input  wire logic                      i_scale_we,
    input  wire pp_cfg_pkg::affine_addr_t  i_waddr,
    input  wire pp_data_pkg::affine_word_u i_wdata,
    output      pp_data_pkg::psum_vec_t    o_bias,
    output      pp_cfg_pkg::shift_t [pp_cfg_pkg::TOUT-1:0] o_shift
);

    import pp_cfg_pkg::*;
    import pp_data_pkg::*;

    localparam int LANE_W = $clog2(TOUT);

    logic              csync_d;
    logic              fetching;
    affine_addr_t      rd_addr;
    logic [LANE_W-1:0] rd_lane;
    logic              cap_vld;
    logic [LANE_W-1:0] cap_lane;
    affine_word_u      bias_rd;
    affine_word_u      scale_rd;

    wire fetch_start = i_csync_run & ~csync_d;

    // one-hot bit k gives shift k+1
    function automatic shift_t scale_to_shift(input logic [7:0] onehot);
        shift_t sh;
        sh = '0;
        for (int k = 0; k < 8; k++) begin
            if (onehot == (8'd1 << k)) begin
                sh = shift_t'(k + 1);
            end
        end
        return sh;
    endfunction

    // ============================================================
    // read sequencer
    // ============================================================
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            csync_d  <= 1'b0;
            fetching <= 1'b0;
            rd_addr  <= '0;
            rd_lane  <= '0;
            cap_vld  <= 1'b0;
            cap_lane <= '0;
        end else begin
            csync_d  <= i_csync_run;
            cap_vld  <= fetching;
            cap_lane <= rd_lane;
            if (fetch_start) begin
                fetching <= 1'b1;
                rd_addr  <= affine_addr_t'(i_chn_out) * affine_addr_t'(TOUT);
                rd_lane  <= '0;
            end else if (fetching) begin
                rd_addr <= rd_addr + 1'b1;
                rd_lane <= rd_lane + 1'b1;
                if (rd_lane == LANE_W'(TOUT - 1)) begin
                    fetching <= 1'b0;
                end
            end
        end
    end

    // lane captured a cycle after its read
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            o_bias  <= '0;
            o_shift <= '0;
        end else if (cap_vld) begin
            o_bias[cap_lane]  <= bias_rd.bias;
            o_shift[cap_lane] <= scale_to_shift(scale_rd.scale.onehot);
        end
    end

    dpram #(.DEPTH(AFFINE_DEPTH), .AW(AFFINE_AW), .DW(AFFINE_DW)) u_bias_ram (
        .clk     (clk),
        .i_we    (i_bias_we),
        .i_waddr (i_waddr),
        .i_wdata (i_wdata),
        .i_re    (fetching),
        .i_raddr (rd_addr),
        .o_rdata (bias_rd)
    );

    dpram #(.DEPTH(AFFINE_DEPTH), .AW(AFFINE_AW), .DW(AFFINE_DW)) u_scale_ram (
        .clk     (clk),
        .i_we    (i_scale_we),
        .i_waddr (i_waddr),
        .i_wdata (i_wdata),
        .i_re    (fetching),
        .i_raddr (rd_addr),
        .o_rdata (scale_rd)
    );

endmodule

`default_nettype wire

/* hdl/psum_accumulator.sv */
`default_nettype none

module psum_accumulator (
    input  wire logic                   clk,
    input  wire logic                   rstn,
    input  wire pp_data_pkg::pe_beat_t  i_pe,
    input  wire pp_data_pkg::psum_vec_t i_bias,
    input  wire pp_cfg_pkg::size_t      i_width,
    input  wire pp_cfg_pkg::chn_t       i_chn_groups,
    output      pp_data_pkg::psum_vec_t o_sum,
    output      logic                   o_final,
    output      pp_cfg_pkg::ofm_addr_t  o_addr
);

    import pp_cfg_pkg::*;
    import pp_data_pkg::*;

    pe_beat_t  s0;
    pe_beat_t  s1;
    pe_beat_t  s2;
    psum_vec_t row_rd;
    psum_vec_t sum_q;
    ofm_addr_t addr0;
    ofm_addr_t addr1;
    ofm_addr_t addr2;

    logic               rd_en;
    logic [PSUM_AW-1:0] rd_addr;
    logic               wr_en;
    logic [PSUM_AW-1:0] wr_addr;

    // ============================================================
    // beat staging
    // ============================================================
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            s0 <= '0;
            s1 <= '0;
            s2 <= '0;
        end else begin
            s0 <= i_pe;
            s1 <= s0;
            s2 <= s1;
        end
    end

    // stage 0: fetch the running sum of this column
    assign rd_en   = s0.vld & ~s0.first;
    assign rd_addr = PSUM_AW'(s0.col);

    // stage 1: first channel starts from bias, later ones from the row buffer
    always_ff @(posedge clk) begin
        if (s1.vld) begin
            for (int k = 0; k < TOUT; k++) begin
                sum_q[k] <= $signed(s1.data[k])
                          + (s1.first ? $signed(i_bias[k]) : $signed(row_rd[k]));
            end
        end
    end

    // stage 2: keep the sum for the next channel
    assign wr_en   = s2.vld & ~s2.last;
    assign wr_addr = PSUM_AW'(s2.col);

    dpram #(.DEPTH(PSUM_DEPTH), .AW(PSUM_AW), .DW(PSUM_DW * TOUT)) u_psum_row (
        .clk     (clk),
        .i_we    (wr_en),
        .i_waddr (wr_addr),
        .i_wdata (sum_q),
        .i_re    (rd_en),
        .i_raddr (rd_addr),
        .o_rdata (row_rd)
    );

    // ============================================================
    // ofm address, aligned with the stages
    // ============================================================
    // pixel index then interleave the output groups
    always_ff @(posedge clk) begin
        addr0 <= ofm_addr_t'(i_pe.row) * ofm_addr_t'(i_width) + ofm_addr_t'(i_pe.col);
        addr1 <= addr0 * ofm_addr_t'(i_chn_groups) + ofm_addr_t'(s0.grp);
        addr2 <= addr1;
    end

    assign o_sum   = sum_q;
    assign o_final = s2.vld & s2.last;
    assign o_addr  = addr2;

endmodule

`default_nettype wire

/* hdl/requantizer.sv */
`default_nettype none

module requantizer (
    input  wire logic                   clk,
    input  wire logic                   rstn,
    input  wire pp_data_pkg::psum_vec_t i_sum,
    input  wire logic                   i_final,
    input  wire pp_cfg_pkg::ofm_addr_t  i_addr,
    input  wire pp_cfg_pkg::shift_t [pp_cfg_pkg::TOUT-1:0] i_shift,
    output      logic                   o_vld,
    output      pp_data_pkg::ofm_word_t o_data,
    output      pp_cfg_pkg::ofm_addr_t  o_addr
);

    import pp_cfg_pkg::*;
    import pp_data_pkg::*;

    logic [TOUT-1:0][PSUM_DW-1:0] act;
    logic [TOUT-1:0][PSUM_DW-1:0] shr;
    ofm_word_t                    word_d;

    // relu, shift, clamp to 8 bits
    always_comb begin
        for (int k = 0; k < TOUT; k++) begin
            act[k] = i_sum[k][PSUM_DW-1] ? '0 : i_sum[k];
            shr[k] = act[k] >> i_shift[k];
            word_d.lane[k] = (|shr[k][PSUM_DW-1:OUT_DW]) ? '1 : shr[k][OUT_DW-1:0];
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            o_vld  <= 1'b0;
            o_data <= '0;
        end else begin
            o_vld  <= i_final;
            o_data <= i_final ? word_d : '0;
        end
    end

    always_ff @(posedge clk) begin
        o_addr <= i_addr;
    end

endmodule

`default_nettype wire

/* hdl/postprocessor.sv */
`default_nettype none

module postprocessor (
    input  wire logic                      clk,
    input  wire logic                      rstn,
    // configuration
    input  wire pp_cfg_pkg::size_t         i_width,
    input  wire pp_cfg_pkg::chn_t          i_chn_groups,
    input  wire pp_cfg_pkg::chn_t          i_chn_out,
    // bias and scale load
    input  wire logic                      i_load_bias,
    input  wire logic                      i_load_scale,
    input  wire pp_data_pkg::affine_word_u i_rd_data,
    input  wire logic                      i_rd_vld,
    output      logic                      o_load_done,
    // group switch
    input  wire logic                      i_csync_run,
    // PE array side
    input  wire pp_data_pkg::pe_beat_t     i_pe,
    output      logic                      o_vld,
    output      pp_data_pkg::ofm_word_t    o_data,
    output      pp_cfg_pkg::ofm_addr_t     o_addr
);

    import pp_cfg_pkg::*;
    import pp_data_pkg::*;

    logic                bias_we;
    logic                scale_we;
    affine_addr_t        waddr;
    affine_word_u        wdata;
    psum_vec_t           bias_vec;
    shift_t [TOUT-1:0]   shift_vec;
    psum_vec_t           acc_sum;
    logic                acc_final;
    ofm_addr_t           acc_addr;

    affine_loader u_loader (
        .clk (clk), .rstn (rstn),
        .i_load_bias (i_load_bias), .i_load_scale (i_load_scale),
        .i_chn_groups (i_chn_groups),
        .i_rd_data (i_rd_data), .i_rd_vld (i_rd_vld),
        .o_bias_we (bias_we), .o_scale_we (scale_we),
        .o_waddr (waddr), .o_wdata (wdata),
        .o_load_done (o_load_done)
    );

    affine_fetch u_fetch (
        .clk (clk), .rstn (rstn),
        .i_csync_run (i_csync_run), .i_chn_out (i_chn_out),
        .i_bias_we (bias_we), .i_scale_we (scale_we),
        .i_waddr (waddr), .i_wdata (wdata),
        .o_bias (bias_vec), .o_shift (shift_vec)
    );

    psum_accumulator u_accum (
        .clk (clk), .rstn (rstn),
        .i_pe (i_pe), .i_bias (bias_vec),
        .i_width (i_width), .i_chn_groups (i_chn_groups),
        .o_sum (acc_sum), .o_final (acc_final), .o_addr (acc_addr)
    );

    requantizer u_requant (
        .clk (clk), .rstn (rstn),
        .i_sum (acc_sum), .i_final (acc_final), .i_addr (acc_addr),
        .i_shift (shift_vec),
        .o_vld (o_vld), .o_data (o_data), .o_addr (o_addr)
    );

endmodule

`default_nettype wire

/* verification/pp_assertions.sv */
`default_nettype none

module pp_assertions (
    input wire logic                   clk,
    input wire logic                   rstn,
    input wire pp_data_pkg::pe_beat_t  i_pe,
    input wire logic                   o_vld,
    input wire pp_data_pkg::ofm_word_t o_data,
    input wire logic                   o_load_done
);

    timeunit 1ns;
    timeprecision 100ps;

    // number of failed assertions
    int fail_count = 0;

    wire final_beat = i_pe.vld & i_pe.last;

    load_done_pulse: assert property (@(posedge clk) disable iff (!rstn)
        o_load_done |=> !o_load_done)
        else begin
            fail_count++;
            $error("o_load_done stayed high for more than one cycle");
        end

    vld_known: assert property (@(posedge clk) disable iff (!rstn) !$isunknown(o_vld))
        else begin
            fail_count++;
            $error("o_vld is unknown after reset");
        end

    // idle output word is all zero
    data_zero_idle: assert property (@(posedge clk) disable iff (!rstn)
        !o_vld |-> (o_data == '0))
        else begin
            fail_count++;
            $error("o_data not zero while o_vld is low");
        end

    beat_latency: assert property (@(posedge clk) disable iff (!rstn)
        $past(final_beat, 4) |-> o_vld)
        else begin
            fail_count++;
            $error("last-channel beat not followed by o_vld four cycles later");
        end

endmodule

`default_nettype wire

/* verification/tb_postprocessor.sv */
`default_nettype none

module tb_postprocessor;

    timeunit 1ns;
    timeprecision 100ps;

    import pp_cfg_pkg::*;
    import pp_data_pkg::*;

    localparam int GROUPS       = 3;
    localparam int WIDTH        = 4;
    localparam int N_WORDS      = GROUPS * TOUT;
    localparam int RESET_CYCLES = 10;
    localparam int DRAIN_LIMIT  = 20;
    // reset, two loads, three fetches, beats of tests 2 to 5, drains
    localparam int TOTAL_CYCLES = RESET_CYCLES + 2 * (N_WORDS + 30) + 3 * 10
                                + 6 + 12 + 3 + 8 + 4 * DRAIN_LIMIT;
    localparam int WATCHDOG_NS  = TOTAL_CYCLES * 4 + 2000;

    logic         clk;
    logic         rstn;
    size_t        i_width;
    chn_t         i_chn_groups;
    chn_t         i_chn_out;
    logic         i_load_bias;
    logic         i_load_scale;
    affine_word_u i_rd_data;
    logic         i_rd_vld;
    logic         o_load_done;
    logic         i_csync_run;
    pe_beat_t     i_pe;
    logic         o_vld;
    ofm_word_t    o_data;
    ofm_addr_t    o_addr;

    // reference model state
    int          bias_mem  [N_WORDS];
    int          scale_mem [N_WORDS];
    int          cur_bias  [TOUT];
    int          cur_shift [TOUT];
    int          col_sum   [WIDTH][TOUT];
    logic [31:0] exp_data  [$];
    ofm_addr_t   exp_addr  [$];
    longint      exp_time  [$];

    int errors;
    int checks;
    int done_pulses;

    postprocessor UUT (
        .clk (clk), .rstn (rstn),
        .i_width (i_width), .i_chn_groups (i_chn_groups), .i_chn_out (i_chn_out),
        .i_load_bias (i_load_bias), .i_load_scale (i_load_scale),
        .i_rd_data (i_rd_data), .i_rd_vld (i_rd_vld), .o_load_done (o_load_done),
        .i_csync_run (i_csync_run), .i_pe (i_pe),
        .o_vld (o_vld), .o_data (o_data), .o_addr (o_addr)
    );

    bind postprocessor pp_assertions u_assertions (
        .clk (clk), .rstn (rstn), .i_pe (i_pe),
        .o_vld (o_vld), .o_data (o_data), .o_load_done (o_load_done)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("Checks failed");
        $finish;
    end

    // ============================================================
    // reference model
    // ============================================================
    // single set bit k in the low byte means shift k+1
    function automatic int shift_for(input int scale);
        logic [7:0] low;
        low = scale[7:0];
        if ($countones(low) != 1) begin
            return 0;
        end
        return $clog2(low) + 1;
    endfunction

    function automatic logic [7:0] requant(input int sum, input int shift);
        int v;
        if (sum < 0) begin
            return 8'd0;
        end
        v = sum >>> shift;
        return (v > 255) ? 8'd255 : v[7:0];
    endfunction

    function automatic ofm_addr_t pixel_addr(input int row, input int col, input int grp);
        int a;
        a = (row * WIDTH + col) * GROUPS + grp;
        return ofm_addr_t'(a);
    endfunction

    task automatic check_value(input string what, input longint got, input longint exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0d ns: %s, got %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic report_test(input string name, input int err0);
        if (errors == err0) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errors - err0);
        end
    endtask

    // output words and load done pulses
    always @(posedge clk) begin
        if (rstn && o_load_done) begin
            done_pulses++;
        end
        if (rstn && o_vld) begin
            if (exp_data.size() == 0) begin
                errors++;
                $display("at %0d ns an output word appeared with no beat waiting for it", $time);
            end else begin
                check_value("output data", longint'(o_data), exp_data.pop_front());
                check_value("output address", o_addr, exp_addr.pop_front());
                check_value("output edge time", $time - 4, exp_time.pop_front());
            end
        end
    end

    // ============================================================
    // drivers
    // ============================================================
    task automatic load_buffer(input bit to_scale);
        @(posedge clk);
        if (to_scale) begin
            i_load_scale <= 1'b1;
        end else begin
            i_load_bias <= 1'b1;
        end
        for (int i = 0; i < N_WORDS; i++) begin
            @(posedge clk);
            i_rd_data <= affine_word_u'(to_scale ? scale_mem[i] : bias_mem[i]);
            i_rd_vld  <= 1'b1;
        end
        @(posedge clk);
        i_rd_vld     <= 1'b0;
        i_load_bias  <= 1'b0;
        i_load_scale <= 1'b0;
    endtask

    task automatic fetch_group(input int g);
        @(posedge clk);
        i_chn_out   <= chn_t'(g);
        i_csync_run <= 1'b1;
        for (int k = 0; k < TOUT; k++) begin
            cur_bias[k]  = bias_mem[g * TOUT + k];
            cur_shift[k] = shift_for(scale_mem[g * TOUT + k]);
        end
        // beats of the new group wait 8 cycles
        repeat (8) @(posedge clk);
        i_csync_run <= 1'b0;
    endtask

    task automatic send_beat(input bit first, input bit last, input int row, input int col,
                             input int grp, input psum_vec_t data);
        pe_beat_t    b;
        logic [31:0] w;
        b       = '0;
        b.vld   = 1'b1;
        b.first = first;
        b.last  = last;
        b.row   = size_t'(row);
        b.col   = size_t'(col);
        b.grp   = chn_t'(grp);
        b.data  = data;
        @(posedge clk);
        i_pe <= b;
        for (int k = 0; k < TOUT; k++) begin
            col_sum[col][k] = (first ? cur_bias[k] : col_sum[col][k]) + int'(data[k]);
            w[8*k +: 8]     = requant(col_sum[col][k], cur_shift[k]);
        end
        if (last) begin
            exp_data.push_back(w);
            exp_addr.push_back(pixel_addr(row, col, grp));
            exp_time.push_back($time + 16);
        end
    endtask

    task automatic idle_pe();
        @(posedge clk);
        i_pe <= '0;
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (exp_data.size() != 0 && n < DRAIN_LIMIT) begin
            @(posedge clk);
            n++;
        end
        if (exp_data.size() != 0) begin
            errors++;
            $display("%0d expected output words never arrived", exp_data.size());
            exp_data.delete();
            exp_addr.delete();
            exp_time.delete();
        end
    endtask

    function automatic psum_vec_t random_vec(input int lo, input int span);
        psum_vec_t d;
        for (int k = 0; k < TOUT; k++) begin
            d[k] = psum_t'(int'($urandom_range(span)) + lo);
        end
        return d;
    endfunction

    // ============================================================
    // directed tests
    // ============================================================
    task automatic test_load();
        int err0;
        int n;
        err0 = errors;
        for (int i = 0; i < 2 * TOUT; i++) begin
            bias_mem[i] = int'($urandom_range(200)) - 100;
        end
        bias_mem[8]  = 0;
        bias_mem[9]  = 5;
        bias_mem[10] = -3;
        bias_mem[11] = 100;
        // group 2 holds the edge cases and the upper bytes are ignored
        scale_mem = '{'h02, 'h5a00_0004, 'h01, 'h08,
                      'h1234_0010, 'h20, 'h40, 'h04,
                      'h01, 'h80, 'h03, 'h00};
        load_buffer(1'b0);
        repeat (6) @(posedge clk);
        check_value("load done pulses after bias load", done_pulses, 0);
        load_buffer(1'b1);
        n = 0;
        while (done_pulses == 0 && n < 20) begin
            @(posedge clk);
            n++;
        end
        repeat (4) @(posedge clk);
        check_value("load done pulses after scale load", done_pulses, 1);
        report_test("load", err0);
    endtask

    task automatic test_single_pass();
        int err0;
        err0 = errors;
        fetch_group(0);
        for (int i = 0; i < 6; i++) begin
            send_beat(1'b1, 1'b1, 2 + i / WIDTH, i % WIDTH, 0, random_vec(-1000, 4000));
        end
        idle_pe();
        wait_drain();
        report_test("single channel", err0);
    endtask

    task automatic test_accumulate();
        int err0;
        err0 = errors;
        for (int ch = 0; ch < 3; ch++) begin
            for (int col = 0; col < WIDTH; col++) begin
                send_beat(ch == 0, ch == 2, 1, col, 0, random_vec(-300, 1200));
            end
        end
        idle_pe();
        wait_drain();
        report_test("accumulate", err0);
    endtask

    task automatic test_saturation();
        int        err0;
        psum_vec_t d;
        err0 = errors;
        fetch_group(2);
        d = {psum_t'(-500), psum_t'(32'h2000_0000), psum_t'(70000), psum_t'(1000)};
        send_beat(1'b1, 1'b1, 0, 0, 2, d);
        d = {psum_t'(100), psum_t'(200), psum_t'(600), psum_t'(-32'sh1000_0000)};
        send_beat(1'b1, 1'b1, 0, 1, 2, d);
        d = {psum_t'(90), psum_t'(50), psum_t'(65000), psum_t'(300)};
        send_beat(1'b1, 1'b1, 0, 2, 2, d);
        idle_pe();
        wait_drain();
        report_test("scale and saturation", err0);
    endtask

    task automatic test_group_switch();
        int err0;
        err0 = errors;
        fetch_group(1);
        for (int ch = 0; ch < 2; ch++) begin
            for (int col = 0; col < WIDTH; col++) begin
                send_beat(ch == 0, ch == 1, 3, col, 1, random_vec(0, 3000));
            end
        end
        idle_pe();
        wait_drain();
        report_test("group switch", err0);
    endtask

    initial begin
        rstn         = 1'b0;
        i_width      = size_t'(WIDTH);
        i_chn_groups = chn_t'(GROUPS);
        i_chn_out    = '0;
        i_load_bias  = 1'b0;
        i_load_scale = 1'b0;
        i_rd_data    = '0;
        i_rd_vld     = 1'b0;
        i_csync_run  = 1'b0;
        i_pe         = '0;
        errors       = 0;
        checks       = 0;
        done_pulses  = 0;
        void'($urandom(73476));
        repeat (RESET_CYCLES) @(posedge clk);
        rstn <= 1'b1;
        repeat (2) @(posedge clk);
        test_load();
        test_single_pass();
        test_accumulate();
        test_saturation();
        test_group_switch();
        repeat (4) @(posedge clk);
        errors += UUT.u_assertions.fail_count;
        $display("tests: 5, checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
hdl/pp_cfg_pkg.sv
hdl/pp_data_pkg.sv
hdl/dpram.sv
hdl/affine_loader.sv
hdl/affine_fetch.sv
hdl/psum_accumulator.sv
hdl/requantizer.sv
hdl/postprocessor.sv
verification/pp_assertions.sv
verification/tb_postprocessor.sv

/* run_sim.sh */
#!/bin/sh
# build and run the postprocessor testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f src.f \
    --top-module tb_postprocessor -Mdir obj_dir -o tb_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "All checks passed" "$LOG"; then
    exit 0
fi
exit 1
